/* sim.f */
+incdir+.
br_pkg.sv
branch_decode.sv
branch_unit.sv
branch_subsys_top.sv
tb_branch_subsys.sv

/* tb_branch_table.svh */
/* Directed branch cases
   Instruction, operands, follower PC and expected outcome for each row */

`ifndef TB_BRANCH_TABLE_SVH
`define TB_BRANCH_TABLE_SVH

// One directed case
typedef struct packed {
    logic [31:0] word;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] next_pc;   // PC of the follower at issue
    logic [1:0]  gap;       // idle cycles before the follower
    logic        need;
    logic [1:0]  rs;
    logic        taken;
    logic [31:0] target;
    logic        call;
    logic        ret;
    logic        flush;
    logic        exc;
} dir_row_t;

dir_row_t rows[$];

task automatic add_row(input logic [31:0] word, input logic [31:0] pc,
                       input logic [31:0] rs1, input logic [31:0] rs2,
                       input logic [31:0] next_pc, input logic [1:0] gap,
                       input logic need, input logic [1:0] rs, input logic taken,
                       input logic [31:0] target, input logic call, input logic ret,
                       input logic flush, input logic exc);
    rows.push_back({word, pc, rs1, rs2, next_pc, gap, need, rs, taken, target,
                    call, ret, flush, exc});
endtask

// Columns: word, pc, rs1, rs2, next pc, gap, need, uses_rs, taken, target,
// call, return, flush, exception
task automatic load_directed_rows();
    // Conditional kinds, signed and unsigned views of bit 31
    add_row(btype_word(BEQ, 1, 2, 16), 'h100, 5, 5, 'h110, 0, 1, 2'b11, 1, 'h110, 0, 0, 0, 0);
    add_row(btype_word(BEQ, 1, 2, 16), 'h100, 5, 6, 'h104, 1, 1, 2'b11, 0, 'h104, 0, 0, 0, 0);
    add_row(btype_word(BNE, 3, 4, -8), 'h200, 1, 2, 'h204, 2, 1, 2'b11, 1, 'h1f8, 0, 0, 1, 0);
    add_row(btype_word(BLT, 5, 6, 32), 'h300, 'h80000000, 1, 'h320, 1, 1, 2'b11, 1, 'h320,
            0, 0, 0, 0);
    add_row(btype_word(BLTU, 5, 6, 32), 'h300, 'h80000000, 1, 'h320, 0, 1, 2'b11, 0, 'h304,
            0, 0, 1, 0);
    add_row(btype_word(BGE, 7, 8, -16), 'h400, 1, 'h80000000, 'h3f0, 2, 1, 2'b11, 1, 'h3f0,
            0, 0, 0, 0);
    add_row(btype_word(BGEU, 7, 8, -16), 'h400, 1, 'h80000000, 'h404, 0, 1, 2'b11, 0, 'h404,
            0, 0, 0, 0);
    add_row(btype_word(BGE, 9, 10, 8), 'h500, 7, 7, 'h508, 1, 1, 2'b11, 1, 'h508, 0, 0, 0, 0);

    // Jumps with call and return marking
    add_row(jtype_word(1, 'h800), 'h1000, 0, 0, 'h1800, 0, 1, 2'b00, 1, 'h1800, 1, 0, 0, 0);
    add_row(jtype_word(0, -1024), 'h2000, 0, 0, 'h2004, 2, 1, 2'b00, 1, 'h1c00, 0, 0, 1, 0);
    add_row(itype_word(JALR, 0, 1, 0), 'h600, 'h3001, 0, 'h3000, 1, 1, 2'b01, 1, 'h3000,
            0, 1, 0, 0);
    add_row(itype_word(JALR, 1, 5, 4), 'h700, 'h4000, 0, 'h4004, 0, 1, 2'b01, 1, 'h4004,
            1, 1, 0, 0);
    add_row(itype_word(JALR, 1, 1, 0), 'h800, 'h5000, 0, 'h5008, 2, 1, 2'b01, 1, 'h5000,
            1, 0, 1, 0);
    add_row(itype_word(JALR, 5, 6, -4), 'h880, 'h6010, 0, 'h600c, 1, 1, 2'b01, 1, 'h600c,
            1, 0, 0, 0);

    // ADDI, not for this unit
    add_row(itype_word(7'b0010011, 1, 2, 5), 'h8c0, 0, 0, 0, 0, 0, 2'b00, 0, 0, 0, 0, 0, 0);

    // Targets off a word boundary
    add_row(btype_word(BEQ, 1, 2, 6), 'h900, 3, 3, 'h906, 0, 1, 2'b11, 1, 'h906, 0, 0, 0, 1);
    add_row(btype_word(BNE, 1, 2, 6), 'h900, 3, 3, 'h904, 1, 1, 2'b11, 0, 'h904, 0, 0, 0, 0);
    add_row(jtype_word(0, 2), 'ha00, 0, 0, 'ha02, 0, 1, 2'b00, 1, 'ha02, 0, 0, 0, 1);
    add_row(itype_word(JALR, 0, 7, 3), 'hb00, 'h100, 0, 'h102, 0, 1, 2'b01, 1, 'h102,
            0, 0, 0, 1);
endtask

`endif

/* tb_branch_subsys.sv */
/* Branch subsystem testbench
   Directed table and random compare loop against the decode and execute halves */

`timescale 1ns/100ps
`default_nettype none

module tb_branch_subsys;
    import br_pkg::*;

    logic        clk;
    logic        rst;
    decode_pkt_t decode;
    logic        decode_advance;
    issue_pkt_t  issue;
    logic        new_request;
    logic        issue_valid;
    logic        unit_needed;
    logic [1:0]  uses_rs;
    logic        uses_rd;
    br_result_t  br_results;
    logic        flush;
    br_exc_t     exc;

    int          errors;
    int          timeouts;
    int          row_idx;
    logic [31:0] rng_state;

    branch_subsys_top uut (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_advance (decode_advance),
        .unit_needed    (unit_needed),
        .uses_rs        (uses_rs),
        .uses_rd        (uses_rd),
        .issue          (issue),
        .new_request    (new_request),
        .issue_valid    (issue_valid),
        .br_results     (br_results),
        .flush          (flush),
        .exc            (exc)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Instruction encoders

    function automatic logic [31:0] btype_word(input logic [2:0] fn3, input logic [4:0] rs1a,
                                               input logic [4:0] rs2a, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2a, rs1a, fn3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // fn3 fixed at 000
    function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [4:0] rs1a, input logic [11:0] imm);
        return {imm, rs1a, 3'b000, rd, opc};
    endfunction

    `include "tb_branch_table.svh"

    ////////////////////////////////////////
    // Reference model and random source

    function automatic logic expect_taken(input br_fn3_t fn, input logic [31:0] a,
                                          input logic [31:0] b);
        case (fn)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    ////////////////////////////////////////
    // Compare tasks

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input br_result_t got, input br_result_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Fields other than valid only matter when one is expected
    task automatic check_exc(input br_exc_t got, input br_exc_t exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Case sequencing

    // Follower instruction arrives at issue
    task automatic present_follower(input logic [31:0] next_pc);
        issue_valid <= 1'b1;
        issue.pc    <= next_pc;
    endtask

    task automatic run_row(input dir_row_t r, input int idx);
        br_result_t exp_res;
        br_exc_t    exp_exc;
        int         k;
        int         waited;
        exp_res = '{valid: 1'b1, id: idx[3:0], pc: r.pc, target_pc: r.target,
                    taken: r.taken, is_branch: (r.word[6:0] == BRANCH),
                    is_call: r.call, is_return: r.ret};
        exp_exc = '{valid: r.exc, code: INST_ADDR_MISALIGNED, tval: r.target, pc: r.pc};

        // Decode cycle
        @(posedge clk);
        decode.instruction <= r.word;
        decode.pc          <= r.pc;
        decode_advance     <= 1'b1;
        @(negedge clk);
        check_flag(unit_needed, r.need, $sformatf("row %0d unit_needed", idx));
        check_flag(uses_rs[0], r.rs[0], $sformatf("row %0d uses_rs[0]", idx));
        check_flag(uses_rs[1], r.rs[1], $sformatf("row %0d uses_rs[1]", idx));
        check_flag(uses_rd, 1'b0, $sformatf("row %0d uses_rd", idx));
        @(posedge clk);
        decode_advance <= 1'b0;
        if (r.need) begin
            // Issue cycle
            new_request   <= 1'b1;
            issue.pc      <= r.pc;
            issue.fn3     <= br_fn3_t'(r.word[14:12]);
            issue.rs1     <= r.rs1;
            issue.rs2     <= r.rs2;
            issue.fall_pc <= r.pc + 32'd4;
            issue.id      <= idx[3:0];
            @(posedge clk);
            new_request <= 1'b0;
            if (r.gap == 0) begin
                present_follower(r.next_pc);
            end
            @(negedge clk);
            check_exc(exc, exp_exc, $sformatf("row %0d exception", idx));
            // Nothing may complete while issue is empty
            for (k = 1; k <= r.gap; k++) begin
                check_flag(br_results.valid, 1'b0, $sformatf("row %0d early result", idx));
                @(posedge clk);
                if (k == r.gap) begin
                    present_follower(r.next_pc);
                end
                @(negedge clk);
            end
            waited = 0;
            while (!br_results.valid && waited < 20) begin
                @(negedge clk);
                waited++;
            end
            if (!br_results.valid) begin
                timeouts++;
                $display("Row %0d: no branch result within 20 cycles of the follower", idx);
            end else begin
                check_result(br_results, exp_res, $sformatf("row %0d result", idx));
                check_flag(flush, r.flush, $sformatf("row %0d flush", idx));
            end
            @(posedge clk);
            issue_valid <= 1'b0;
        end
    endtask

    // Random conditional branches, word-aligned targets
    task automatic run_random(input int count);
        br_fn3_t     kinds[6];
        dir_row_t    row;
        br_fn3_t     fn;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [12:0] imm;
        logic [31:0] pc;
        int          n;
        kinds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        for (n = 0; n < count; n++) begin
            r  = next_rand();
            fn = kinds[r[15:0] % 6];
            a  = next_rand();
            r  = next_rand();
            // Equal, bit 31 only, or unrelated
            case (r % 3)
                0:       b = a;
                1:       b = a ^ 32'h8000_0000;
                default: b = next_rand();
            endcase
            r   = next_rand();
            imm = {r[12:2], 2'b00};
            pc  = {14'h0001, r[17:2], 2'b00};
            row = '0;
            row.word   = btype_word(fn, 5'd10, 5'd11, imm);
            row.pc     = pc;
            row.rs1    = a;
            row.rs2    = b;
            row.gap    = r[19:18] % 3;
            row.need   = 1'b1;
            row.rs     = 2'b11;
            row.taken  = expect_taken(fn, a, b);
            row.target = row.taken ? pc + {{19{imm[12]}}, imm} : pc + 32'd4;
            row.next_pc = r[20] ? row.target : pc + 32'd4;
            row.flush  = (row.next_pc[31:1] != row.target[31:1]);
            run_row(row, 100 + n);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        decode         = '0;
        decode_advance = 1'b0;
        issue          = '0;
        new_request    = 1'b0;
        issue_valid    = 1'b0;
        errors         = 0;
        timeouts       = 0;
        rng_state      = 32'd61849;
        load_directed_rows();

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            run_row(rows[row_idx], row_idx);
        end
        run_random(48);

        repeat (2) @(posedge clk);
        $display("Errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* branch_subsys_top.sv */
/* Branch subsystem top
   Decode and execute halves joined by the pre-computed branch record */

`timescale 1ns/100ps
`default_nettype none

module branch_subsys_top (
    input  wire logic                clk,
    input  wire logic                rst,

    // Decode side
    input  wire br_pkg::decode_pkt_t decode,
    input  wire logic                decode_advance,
    output logic                     unit_needed,
    output logic [1:0]               uses_rs,
    output logic                     uses_rd,

    // Issue side
    input  wire br_pkg::issue_pkt_t  issue,
    input  wire logic                new_request,
    input  wire logic                issue_valid,

    // Outcome
    output br_pkg::br_result_t       br_results,
    output logic                     flush,
    output br_pkg::br_exc_t          exc
);
    import br_pkg::*;

    // Record for the instruction that issues next
    br_pre_t pre;

    ////////////////////////////////////////
    // Decode half

    branch_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .decode         (decode),
        .decode_advance (decode_advance),
        .unit_needed    (unit_needed),
        .uses_rs        (uses_rs),
        .uses_rd        (uses_rd),
        .pre            (pre)
    );

    ////////////////////////////////////////
    // Execute half

    branch_unit u_unit (
        .clk         (clk),
        .rst         (rst),
        .pre         (pre),
        .issue       (issue),
        .new_request (new_request),
        .issue_valid (issue_valid),
        .br_results  (br_results),
        .flush       (flush),
        .exc         (exc)
    );

endmodule

`default_nettype wire

/* branch_unit.sv */
/* Branch execute
   Compares operands, resolves target, reports outcome, flush and misaligned fetch */

`timescale 1ns/100ps
`default_nettype none

`include "br_cfg.svh"

module branch_unit (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire br_pkg::br_pre_t     pre,
    input  wire br_pkg::issue_pkt_t  issue,
    input  wire logic                new_request,
    input  wire logic                issue_valid,
    output br_pkg::br_result_t       br_results,
    output logic                     flush,
    output br_pkg::br_exc_t          exc
);
    import br_pkg::*;

    // Operands with one extra sign bit
    logic [`BR_XLEN:0] rs1_x;
    logic [`BR_XLEN:0] rs2_x;
    logic ops_eq;
    logic ops_lt;
    logic cmp_hit;
    logic taken;

    // Target path
    logic [`BR_XLEN-1:0] base;
    logic [`BR_XLEN-1:0] ofs_x;
    logic [`BR_XLEN-1:0] sum;
    logic [`BR_XLEN-1:0] jump_pc;
    logic [`BR_XLEN-1:0] new_pc;

    // Registered outcome
    logic                taken_r;
    logic [`BR_XLEN-1:0] target_r;
    logic [`BR_XLEN-1:0] pc_r;
    id_t                 id_r;
    logic                is_jump_r;
    logic                is_call_r;
    logic                is_return_r;

    logic pending;
    logic completing;
    logic exc_fire;

    ////////////////////////////////////////
    // Comparison

    // Unsigned kinds see a zero top bit
    assign rs1_x = {issue.rs1[`BR_XLEN-1] & pre.use_signed, issue.rs1};
    assign rs2_x = {issue.rs2[`BR_XLEN-1] & pre.use_signed, issue.rs2};

    assign ops_eq = (rs1_x == rs2_x);
    assign ops_lt = ($signed(rs1_x) < $signed(rs2_x));

    // fn3[2] picks less-than, fn3[0] negates
    assign cmp_hit = (issue.fn3[2] ? ops_lt : ops_eq) ^ issue.fn3[0];

    // Jumps always redirect
    assign taken = cmp_hit | pre.is_jump;

    ////////////////////////////////////////
    // Target calculation

    assign base  = pre.is_jalr ? issue.rs1 : issue.pc;
    assign ofs_x = {{(`BR_XLEN-`BR_OFS_W){pre.offset[`BR_OFS_W-1]}}, pre.offset};
    assign sum   = base + ofs_x;

    // JALR drops bit 0 of the sum
    assign jump_pc = {sum[`BR_XLEN-1:1], sum[0] & ~pre.is_jalr};

    // Not taken falls through
    assign new_pc = taken ? jump_pc : issue.fall_pc;

    ////////////////////////////////////////
    // Outcome registers

    always_ff @(posedge clk) begin
        if (new_request) begin
            taken_r     <= taken;
            target_r    <= new_pc;
            pc_r        <= issue.pc;
            id_r        <= issue.id;
            is_jump_r   <= pre.is_jump;
            is_call_r   <= pre.is_call;
            is_return_r <= pre.is_return;
        end
    end

    // Held until the next instruction shows up at issue
    // A request in the completing cycle wins over the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (new_request) begin
            pending <= 1'b1;
        end else if (issue_valid | exc_fire) begin
            pending <= 1'b0;
        end
    end

    assign completing = pending & issue_valid;

    ////////////////////////////////////////
    // Result and flush

    always_comb begin
        br_results.valid     = completing;
        br_results.id        = id_r;
        br_results.pc        = pc_r;
        br_results.target_pc = target_r;
        br_results.taken     = taken_r;
        br_results.is_branch = ~is_jump_r;
        br_results.is_call   = is_call_r;
        br_results.is_return = is_return_r;
    end

    // Redirect when the follower is not at the resolved target
    assign flush = completing &
                   (issue.pc[`BR_XLEN-1:1] != target_r[`BR_XLEN-1:1]);

    ////////////////////////////////////////
    // Misaligned target

    generate
        if (`BR_MISALIGN_EXC) begin : g_misalign_exc
            // Fires the cycle after a taken request off a word boundary
            always_ff @(posedge clk) begin
                if (rst) begin
                    exc_fire <= 1'b0;
                end else begin
                    exc_fire <= new_request & taken & jump_pc[1];
                end
            end

            always_comb begin
                exc.valid = exc_fire;
                exc.code  = INST_ADDR_MISALIGNED;
                exc.tval  = target_r;
                exc.pc    = pc_r;
            end
        end else begin : g_no_exc
            assign exc_fire = 1'b0;

            // Port tied off
            always_comb begin
                exc.valid = 1'b0;
                exc.code  = INST_ADDR_MISALIGNED;
                exc.tval  = '0;
                exc.pc    = '0;
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* branch_decode.sv */
/* Branch decode
   Classifies branch, JAL and JALR words and prepares offset and call/return flags */

`timescale 1ns/100ps
`default_nettype none

`include "br_cfg.svh"

module branch_decode (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire br_pkg::decode_pkt_t  decode,
    input  wire logic                 decode_advance,
    output logic                      unit_needed,
    output logic [1:0]                uses_rs,
    output logic                      uses_rd,
    output br_pkg::br_pre_t           pre
);
    import br_pkg::*;

    rv_instr_t instr;

    logic is_cond;
    logic is_jal;
    logic is_jalr;

    logic [19:0] jal_imm;
    logic [11:0] jalr_imm;
    logic [11:0] br_imm;
    logic signed [`BR_OFS_W-1:0] offset;

    logic rs1_link;
    logic rd_link;
    logic call_d;
    logic return_d;

    ////////////////////////////////////////
    // Classification

    assign instr = rv_instr_t'(decode.instruction);

    // fn3 010 and 011 are not branches
    assign is_cond = (instr.opcode == BRANCH) &&
                     (instr.fn3 inside {BEQ, BNE, BLT, BGE, BLTU, BGEU});
    assign is_jal  = (instr.opcode == JAL);
    assign is_jalr = (instr.opcode == JALR) && (instr.fn3 == 3'b000);

    assign unit_needed = is_cond | is_jal | is_jalr;

    // Bit 0 rs1, bit 1 rs2
    assign uses_rs = {is_cond, is_cond | is_jalr};

    // Link writes go through the ALU
    assign uses_rd = 1'b0;

    ////////////////////////////////////////
    // Offset extraction

    // J-type, bit 0 implied zero
    assign jal_imm = {decode.instruction[31], decode.instruction[19:12],
                      decode.instruction[20], decode.instruction[30:21]};

    // I-type
    assign jalr_imm = decode.instruction[31:20];

    // B-type, bit 0 implied zero
    assign br_imm = {decode.instruction[31], decode.instruction[7],
                     decode.instruction[30:25], decode.instruction[11:8]};

    always_comb begin
        if (is_jal) begin
            offset = {jal_imm, 1'b0};
        end else if (is_jalr) begin
            offset = {{(`BR_OFS_W-12){jalr_imm[11]}}, jalr_imm};
        end else begin
            offset = {{(`BR_OFS_W-13){br_imm[11]}}, br_imm, 1'b0};
        end
    end

    ////////////////////////////////////////
    // Call and return hints

    assign rs1_link = instr.rs1_addr inside {5'd1, 5'd5};
    assign rd_link  = instr.rd_addr inside {5'd1, 5'd5};

    // Any jump writing a link register
    assign call_d = (is_jal | is_jalr) & rd_link;

    // Pop unless rd pushes the same link register back
    assign return_d = is_jalr & rs1_link &
                      (~rd_link | (instr.rs1_addr != instr.rd_addr));

    ////////////////////////////////////////
    // Handoff to execute

    // Kind flags
    always_ff @(posedge clk) begin
        if (rst) begin
            pre.is_jalr   <= 1'b0;
            pre.is_jump   <= 1'b0;
            pre.is_call   <= 1'b0;
            pre.is_return <= 1'b0;
        end else if (decode_advance) begin
            pre.is_jalr   <= is_jalr;
            pre.is_jump   <= is_jal | is_jalr;
            pre.is_call   <= call_d;
            pre.is_return <= return_d;
        end
    end

    // Operand data for the issuing instruction
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            pre.offset     <= offset;
            pre.use_signed <= !(instr.fn3 inside {BLTU, BGEU});
            pre.spare      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* br_pkg.sv */
/* Branch unit types
   Opcode and function encodings, pipeline packets and result records */

`default_nettype none

`include "br_cfg.svh"

package br_pkg;

    ////////////////////////////////////////
    // Encodings

    // Major opcodes handled by the unit
    typedef enum logic [6:0] {
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    // Conditional branch fn3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_fn3_t;

    // Only the misaligned fetch code is raised here
    typedef enum logic [4:0] {
        INST_ADDR_MISALIGNED = 5'd0
    } exc_code_t;

    ////////////////////////////////////////
    // Common fields

    typedef logic [`BR_XLEN-1:0] addr_t;
    typedef logic [`BR_ID_W-1:0] id_t;

    // Base instruction layout, R-type field positions
    typedef struct packed {
        logic [6:0] fn7;
        logic [4:0] rs2_addr;
        logic [4:0] rs1_addr;
        logic [2:0] fn3;
        logic [4:0] rd_addr;
        logic [6:0] opcode;
    } rv_instr_t;

    ////////////////////////////////////////
    // Pipeline packets

    // Word and PC seen at decode
    typedef struct packed {
        logic [31:0] instruction;
        addr_t       pc;
    } decode_pkt_t;

    // Fields travelling with the issuing branch
    typedef struct packed {
        addr_t   pc;
        br_fn3_t fn3;
        addr_t   rs1;
        addr_t   rs2;
        addr_t   fall_pc;   // pc + 4 from the ALU
        id_t     id;
    } issue_pkt_t;

    // Decode-side record handed to execute
    typedef struct packed {
        logic signed [`BR_OFS_W-1:0] offset;
        logic is_jalr;
        logic is_jump;
        logic use_signed;
        logic is_call;
        logic is_return;
        logic spare;
    } br_pre_t;

    // Outcome for the predictor and return-address stack
    typedef struct packed {
        logic  valid;
        id_t   id;
        addr_t pc;
        addr_t target_pc;
        logic  taken;
        logic  is_branch;
        logic  is_call;
        logic  is_return;
    } br_result_t;

    // Exception report
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        addr_t     tval;
        addr_t     pc;
    } br_exc_t;

endpackage

`default_nettype wire

/* br_cfg.svh */
/* Branch unit configuration
   Data width, ID tag width and misaligned-target exception enable */

`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// Data and PC width
`define BR_XLEN 32

// Instruction ID tag width
`define BR_ID_W 4

// Misaligned-target exception
// 1 builds the exception logic, 0 ties the exception port off
`define BR_MISALIGN_EXC 1'b1

// Width of the pre-computed PC offset
`define BR_OFS_W 21

`endif
